// ==== source/camera_pkg.sv ====
`default_nettype none

package camera_pkg;

  // sensor frame geometry (720p output mode)
  localparam int unsigned SENSOR_WIDTH  = 1280;
  localparam int unsigned SENSOR_HEIGHT = 720;

  localparam int unsigned HCOUNT_BITS = $clog2(SENSOR_WIDTH);  // 11 bits
  localparam int unsigned VCOUNT_BITS = $clog2(SENSOR_HEIGHT); // 10 bits

  // flops per pin in the input synchronizer
  localparam int unsigned SYNC_STAGES = 2;

  typedef logic [7:0] cam_byte_t; // one byte from the parallel bus

  // rgb565, first byte of a pair lands in [15:8]
  // [15:11] red, [10:5] green, [4:0] blue
  typedef logic [15:0] pixel_t;

  typedef logic [HCOUNT_BITS-1:0] hcount_t; // sensor column index
  typedef logic [VCOUNT_BITS-1:0] vcount_t; // sensor line index

  // which half of the pixel the next captured byte supplies
  typedef enum logic {
    phase_upper,
    phase_lower
  } byte_phase_e;

endpackage

`default_nettype wire

// ==== source/frame_buffer_pkg.sv ====
`default_nettype none

package frame_buffer_pkg;

  // stored image after down-sampling the 1280x720 sensor frame
  localparam int unsigned FB_WIDTH  = 320;
  localparam int unsigned FB_HEIGHT = 180;

  localparam int unsigned FB_DEPTH = FB_WIDTH * FB_HEIGHT; // 57600 words

  // keep one pixel in 2**DOWNSAMPLE_SHIFT per dimension
  localparam int unsigned DOWNSAMPLE_SHIFT = 2;

  localparam int unsigned FB_ADDR_BITS = $clog2(FB_DEPTH); // 16 bits

  // word address into the frame buffer, row major
  typedef logic [FB_ADDR_BITS-1:0] fb_addr_t;

endpackage

`default_nettype wire

// ==== source/camera_input_sync.sv ====
`timescale 1ns/1ns
`default_nettype none

module camera_input_sync import camera_pkg::*; (
  input  wire        clk_camera,
  input  wire        sys_rst_camera,
  input  cam_byte_t  cam_data_i,  // async sensor pins
  input  wire        cam_pclk_i,
  input  wire        cam_hsync_i,
  input  wire        cam_vsync_i,
  output cam_byte_t  data_o,      // SYNC_STAGES cycles behind the pins
  output logic       pclk_o,
  output logic       hsync_o,
  output logic       vsync_o
);

  cam_byte_t              data_sync [SYNC_STAGES]; // index 0 is the pin side
  logic [SYNC_STAGES-1:0] pclk_sync;
  logic [SYNC_STAGES-1:0] hsync_sync;
  logic [SYNC_STAGES-1:0] vsync_sync;

  // data bus chain, only qualified by the control pins downstream
  always_ff @(posedge clk_camera) begin
    data_sync[0] <= cam_data_i;
    for (int i = 1; i < SYNC_STAGES; i++) begin
      data_sync[i] <= data_sync[i-1];
    end
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      pclk_sync  <= '1; // high so a pclk already up at release is no edge
      hsync_sync <= '0;
      vsync_sync <= '0; // reads as outside a frame
    end else begin
      pclk_sync  <= {pclk_sync[SYNC_STAGES-2:0], cam_pclk_i};
      hsync_sync <= {hsync_sync[SYNC_STAGES-2:0], cam_hsync_i};
      vsync_sync <= {vsync_sync[SYNC_STAGES-2:0], cam_vsync_i};
    end
  end

  assign data_o  = data_sync[SYNC_STAGES-1];
  assign pclk_o  = pclk_sync[SYNC_STAGES-1];
  assign hsync_o = hsync_sync[SYNC_STAGES-1];
  assign vsync_o = vsync_sync[SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== source/pixel_reconstruct.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_reconstruct import camera_pkg::*; (
  input  wire        clk_camera,
  input  wire        sys_rst_camera,
  input  cam_byte_t  cam_data_i,     // synchronized sensor bus
  input  wire        cam_pclk_i,
  input  wire        cam_hsync_i,
  input  wire        cam_vsync_i,
  output logic       pixel_valid_o,  // one cycle per completed pixel
  output pixel_t     pixel_data_o,
  output hcount_t    pixel_hcount_o, // column of the pixel in pixel_data_o
  output vcount_t    pixel_vcount_o  // line of the pixel in pixel_data_o
);

  logic        pclk_prev;   // pclk one cycle ago
  logic        pclk_rise;
  logic        hsync_prev;  // hsync seen at the previous pclk edge
  byte_phase_e phase;
  cam_byte_t   upper_byte;  // first byte of the pair in progress
  hcount_t     hcount;
  vcount_t     vcount;

  // rising edge of the sampled pixel clock, one cycle wide
  assign pclk_rise = cam_pclk_i && !pclk_prev;

  // control path: edge history, byte phase, counters, valid pulse
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      pclk_prev     <= 1'b1; // set, so a pclk high at release is not taken as an edge
      hsync_prev    <= 1'b0;
      phase         <= phase_upper;
      hcount        <= '0;
      vcount        <= '0;
      pixel_valid_o <= 1'b0;
    end else begin
      pclk_prev     <= cam_pclk_i;
      pixel_valid_o <= 1'b0; // default, pulse only on pair completion

      // column moves on once the pulse has carried the current index
      if (pixel_valid_o) begin
        hcount <= hcount + hcount_t'(1);
      end

      if (pclk_rise) begin
        hsync_prev <= cam_hsync_i;
        if (!cam_vsync_i) begin
          // vertical blanking, start of a new frame
          hcount <= '0;
          vcount <= '0;
          phase  <= phase_upper;
        end else if (!cam_hsync_i) begin
          // horizontal blanking, drops any half pixel left on the line
          hcount <= '0;
          phase  <= phase_upper;
          if (hsync_prev) begin
            vcount <= vcount + vcount_t'(1); // first blank edge after a line
          end
        end else if (phase == phase_upper) begin
          phase <= phase_lower;
        end else begin
          phase         <= phase_upper;
          pixel_valid_o <= 1'b1;
        end
      end
    end
  end

  // payload path, qualified by phase and pixel_valid_o
  always_ff @(posedge clk_camera) begin
    if (pclk_rise && cam_vsync_i && cam_hsync_i) begin
      if (phase == phase_upper) begin
        upper_byte <= cam_data_i;                  // red + green[5:3]
      end else begin
        pixel_data_o <= {upper_byte, cam_data_i}; // lower byte is green[2:0] + blue
      end
    end
  end

  assign pixel_hcount_o = hcount;
  assign pixel_vcount_o = vcount;

endmodule

`default_nettype wire

// ==== source/frame_writer.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_writer
  import camera_pkg::*;
  import frame_buffer_pkg::*;
(
  input  wire       clk_camera,
  input  wire       sys_rst_camera,
  input  wire       pixel_valid_i,
  input  pixel_t    pixel_data_i,
  input  hcount_t   pixel_hcount_i,
  input  vcount_t   pixel_vcount_i,
  output fb_addr_t  fb_addr_o,  // held until the next write
  output pixel_t    fb_data_o,
  output logic      fb_we_o     // one cycle per stored pixel
);

  logic     keep;     // pixel lands on the down-sampled grid
  hcount_t  col_ds;   // column after down-sampling
  vcount_t  row_ds;   // line after down-sampling
  fb_addr_t row_base; // first word of the stored row
  fb_addr_t wr_addr;

  // both low index bits zero, one pixel kept per 4x4 block
  assign keep = pixel_valid_i
             && (pixel_hcount_i[DOWNSAMPLE_SHIFT-1:0] == '0)
             && (pixel_vcount_i[DOWNSAMPLE_SHIFT-1:0] == '0);

  assign col_ds   = pixel_hcount_i >> DOWNSAMPLE_SHIFT; // 0..319
  assign row_ds   = pixel_vcount_i >> DOWNSAMPLE_SHIFT; // 0..179
  assign row_base = fb_addr_t'(row_ds * FB_WIDTH);
  assign wr_addr  = row_base + fb_addr_t'(col_ds); // row major

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      fb_we_o <= 1'b0;
    end else begin
      fb_we_o <= keep; // pixel_valid_i is a pulse, so this is too
    end
  end

  // address and pixel only move on a kept pixel
  always_ff @(posedge clk_camera) begin
    if (keep) begin
      fb_addr_o <= wr_addr;
      fb_data_o <= pixel_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/camera_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module camera_capture
  import camera_pkg::*;
  import frame_buffer_pkg::*;
(
  input  wire        clk_camera,
  input  wire        sys_rst_camera,
  input  cam_byte_t  cam_data_i,  // parallel sensor pins, async
  input  wire        cam_pclk_i,
  input  wire        cam_hsync_i,
  input  wire        cam_vsync_i,
  output fb_addr_t   fb_addr_o,   // write port of the 320x180 frame buffer
  output pixel_t     fb_data_o,
  output logic       fb_we_o
);

  cam_byte_t data_sync;
  logic      pclk_sync;
  logic      hsync_sync;
  logic      vsync_sync;

  logic      pixel_valid;
  pixel_t    pixel_data;
  hcount_t   pixel_hcount;
  vcount_t   pixel_vcount;

  // pins into the camera clock domain, 2 cycles
  camera_input_sync i_camera_input_sync (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .cam_data_i     (cam_data_i),
    .cam_pclk_i     (cam_pclk_i),
    .cam_hsync_i    (cam_hsync_i),
    .cam_vsync_i    (cam_vsync_i),
    .data_o         (data_sync),
    .pclk_o         (pclk_sync),
    .hsync_o        (hsync_sync),
    .vsync_o        (vsync_sync)
  );

  // byte pairs to rgb565 plus sensor coordinates, 1 cycle
  pixel_reconstruct i_pixel_reconstruct (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .cam_data_i     (data_sync),
    .cam_pclk_i     (pclk_sync),
    .cam_hsync_i    (hsync_sync),
    .cam_vsync_i    (vsync_sync),
    .pixel_valid_o  (pixel_valid),
    .pixel_data_o   (pixel_data),
    .pixel_hcount_o (pixel_hcount),
    .pixel_vcount_o (pixel_vcount)
  );

  // 4x down-sample and write strobe, 1 cycle
  frame_writer i_frame_writer (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .pixel_valid_i  (pixel_valid),
    .pixel_data_i   (pixel_data),
    .pixel_hcount_i (pixel_hcount),
    .pixel_vcount_i (pixel_vcount),
    .fb_addr_o      (fb_addr_o),
    .fb_data_o      (fb_data_o),
    .fb_we_o        (fb_we_o)
  );

endmodule

`default_nettype wire

// ==== bench/camera_capture_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module camera_capture_props
  import frame_buffer_pkg::*;
(
  input wire      clk_camera,
  input wire      sys_rst_camera,
  input wire      fb_we_i,    // write strobe of the frame writer
  input fb_addr_t fb_addr_i   // write address of the frame writer
);

  // one strobe per kept pixel, pixels are at least 8 clocks apart
  we_single_cycle: assert property (
    @(posedge clk_camera) disable iff (sys_rst_camera)
      fb_we_i |=> !fb_we_i
  ) else $error("fb_we_o high for two cycles in a row");

  // 320x180 buffer, nothing past the last word
  addr_in_range: assert property (
    @(posedge clk_camera) disable iff (sys_rst_camera)
      fb_we_i |-> (32'(fb_addr_i) < FB_DEPTH)
  ) else $error("fb_addr_o %h outside the frame buffer", fb_addr_i);

  // no strobe can leak out of reset
  we_low_after_reset: assert property (
    @(posedge clk_camera)
      sys_rst_camera |=> !fb_we_i
  ) else $error("fb_we_o high in the cycle after reset");

endmodule

bind frame_writer camera_capture_props i_camera_capture_props (
  .clk_camera     (clk_camera),
  .sys_rst_camera (sys_rst_camera),
  .fb_we_i        (fb_we_o),
  .fb_addr_i      (fb_addr_o)
);

`default_nettype wire

// ==== bench/tb_camera_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_camera_capture
  import camera_pkg::*;
  import frame_buffer_pkg::*;
();

  localparam int CLK_PERIOD      = 8;
  localparam int CYCLES_PER_BYTE = 4;  // pclk toggles every 2 clocks
  localparam int H_GAP           = 3;  // hsync-low pclk periods around a line
  localparam int V_GAP           = 4;  // vsync-low pclk periods per frame start
  localparam int DRAIN_CYCLES    = 32;

  // one frame per row: geometry and byte pattern, then expected totals
  localparam int NUM_ROWS = 4;
  localparam int ROW_WIDTH     [NUM_ROWS] = '{24, 17, 40, 9};  // pixels per line
  localparam int ROW_LINES     [NUM_ROWS] = '{13, 9, 22, 6};
  localparam bit ROW_RANDOM    [NUM_ROWS] = '{1'b1, 1'b0, 1'b1, 1'b0}; // else counting
  localparam bit ROW_ODD       [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1}; // stray last byte
  localparam int ROW_WRITES    [NUM_ROWS] = '{24, 15, 60, 6};
  localparam int ROW_LAST_ADDR [NUM_ROWS] = '{965, 644, 1609, 322};

  logic      clk_camera;
  logic      sys_rst_camera;
  cam_byte_t cam_data;
  logic      cam_pclk;
  logic      cam_hsync;
  logic      cam_vsync;
  fb_addr_t  fb_addr;
  pixel_t    fb_data;
  logic      fb_we;

  fb_addr_t  expected_addr_q[$];  // one entry per write still to come
  pixel_t    expected_data_q[$];
  fb_addr_t  popped_addr;
  pixel_t    popped_data;
  logic      we_prev = 1'b0;
  int        writes_in_frame = 0;
  fb_addr_t  last_write_addr = '0;
  int        cycle_count;
  int        cycle_limit;
  int        mismatch_count = 0;
  int        unexpected_count = 0;
  int        missing_count = 0;
  int        other_count = 0;

  camera_capture i_camera_capture (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .cam_data_i     (cam_data),
    .cam_pclk_i     (cam_pclk),
    .cam_hsync_i    (cam_hsync),
    .cam_vsync_i    (cam_vsync),
    .fb_addr_o      (fb_addr),
    .fb_data_o      (fb_data),
    .fb_we_o        (fb_we)
  );

  initial begin
    clk_camera = 1'b0;
    forever #(CLK_PERIOD / 2) clk_camera = ~clk_camera;
  end

  // nominal run length from the table, doubled for margin
  function automatic int run_cycle_limit();
    int periods;
    periods = 8; // reset and final frame close
    for (int r = 0; r < NUM_ROWS; r++) begin
      periods += ROW_LINES[r] * (2 * ROW_WIDTH[r] + int'(ROW_ODD[r]));
      periods += V_GAP + H_GAP * (ROW_LINES[r] + 1);
    end
    return 2 * periods * CYCLES_PER_BYTE + NUM_ROWS * DRAIN_CYCLES;
  endfunction

  function automatic cam_byte_t pattern_byte(input bit random_bytes, input int index);
    if (random_bytes) begin
      return cam_byte_t'($urandom);
    end
    return cam_byte_t'(index); // counting, wraps at 256
  endfunction

  // one pclk period on the pins, low for two clocks then high for two
  task automatic drive_pclk_period(input cam_byte_t value, input logic hs, input logic vs);
    @(negedge clk_camera);
    cam_pclk  = 1'b0;
    cam_data  = value;
    cam_hsync = hs;
    cam_vsync = vs;
    @(negedge clk_camera);
    @(negedge clk_camera);
    cam_pclk = 1'b1; // sensor byte taken on this edge
    @(negedge clk_camera);
  endtask

  // hsync low with junk on the bus, vsync level picks line or frame blanking
  task automatic drive_blank(input int periods, input logic vsync_level);
    for (int i = 0; i < periods; i++) begin
      drive_pclk_period(cam_byte_t'($urandom), 1'b0, vsync_level);
    end
  endtask

  task automatic send_frame(input int row);
    int        byte_index;
    cam_byte_t upper;
    cam_byte_t lower;
    byte_index = 0;
    drive_blank(V_GAP, 1'b0); // counters and byte phase clear
    drive_blank(H_GAP, 1'b1);
    for (int line = 0; line < ROW_LINES[row]; line++) begin
      for (int col = 0; col < ROW_WIDTH[row]; col++) begin
        upper = pattern_byte(ROW_RANDOM[row], byte_index);
        lower = pattern_byte(ROW_RANDOM[row], byte_index + 1);
        byte_index += 2;
        // only the 4x4 grid is stored, 320 words per stored row
        if (line % 4 == 0 && col % 4 == 0) begin
          expected_addr_q.push_back(fb_addr_t'((line / 4) * FB_WIDTH + col / 4));
          expected_data_q.push_back({upper, lower}); // first byte is the upper half
        end
        drive_pclk_period(upper, 1'b1, 1'b1);
        drive_pclk_period(lower, 1'b1, 1'b1);
      end
      if (ROW_ODD[row]) begin
        // half pixel, must be dropped at the hsync gap
        drive_pclk_period(pattern_byte(ROW_RANDOM[row], byte_index), 1'b1, 1'b1);
        byte_index++;
      end
      drive_blank(H_GAP, 1'b1); // first low edge moves to the next line
    end
  endtask

  // pipeline needs a few clocks to deliver the last queued writes
  task automatic wait_for_writes();
    int waited;
    waited = 0;
    while (expected_addr_q.size() != 0 && waited < DRAIN_CYCLES) begin
      @(negedge clk_camera);
      waited++;
    end
  endtask

  task automatic check_frame(input int row);
    wait_for_writes();
    if (expected_addr_q.size() != 0) begin
      missing_count += expected_addr_q.size();
      $display("frame %0d ended with %0d expected writes that never came",
               row, expected_addr_q.size());
      expected_addr_q.delete();
      expected_data_q.delete();
    end
    if (writes_in_frame != ROW_WRITES[row]) begin
      mismatch_count++;
      $display("mismatch fb_we_o count in frame %0d: got %h expected %h",
               row, writes_in_frame, ROW_WRITES[row]);
    end
    if (last_write_addr !== fb_addr_t'(ROW_LAST_ADDR[row])) begin
      mismatch_count++;
      $display("mismatch fb_addr_o last in frame %0d: got %h expected %h",
               row, last_write_addr, fb_addr_t'(ROW_LAST_ADDR[row]));
    end
    writes_in_frame = 0;
  endtask

  task automatic check_strobe_low(input string when_text);
    if (fb_we !== 1'b0) begin
      other_count++;
      $display("write strobe not low %s", when_text);
    end
  endtask

  // write port consumer, sampled mid-cycle where outputs have settled
  always @(negedge clk_camera) begin
    if (fb_we === 1'b1) begin
      writes_in_frame++;
      last_write_addr = fb_addr;
      if (we_prev) begin
        other_count++;
        $display("write strobe high for two cycles in a row at %0t", $time);
      end
      if (32'(fb_addr) >= FB_DEPTH) begin
        other_count++;
        $display("write address %h is outside the frame buffer", fb_addr);
      end
      if (expected_addr_q.size() == 0) begin
        unexpected_count++;
        $display("unexpected write to address %h at %0t", fb_addr, $time);
      end else begin
        popped_addr = expected_addr_q.pop_front();
        popped_data = expected_data_q.pop_front();
        if (fb_addr !== popped_addr) begin
          mismatch_count++;
          $display("mismatch fb_addr_o: got %h expected %h", fb_addr, popped_addr);
        end
        if (fb_data !== popped_data) begin
          mismatch_count++;
          $display("mismatch fb_data_o: got %h expected %h", fb_data, popped_data);
        end
      end
    end
    we_prev = (fb_we === 1'b1);
  end

  initial begin
    cycle_limit = run_cycle_limit();
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk_camera);
      cycle_count++;
    end
    $display("timeout: no result after %0d clock cycles", cycle_limit);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    void'($urandom(32'h967f)); // one seed for the whole run
    sys_rst_camera = 1'b1;
    cam_data       = 8'h00;
    cam_pclk       = 1'b0;
    cam_hsync      = 1'b1; // active framing during reset
    cam_vsync      = 1'b1;

    @(negedge clk_camera);
    check_strobe_low("during reset");
    cam_pclk = 1'b1; // pclk edge while reset is held
    cam_data = cam_byte_t'($urandom);
    @(negedge clk_camera);
    check_strobe_low("during reset");
    sys_rst_camera = 1'b0; // two rising clock edges in reset
    repeat (4) begin
      @(negedge clk_camera);
      check_strobe_low("right after reset");
    end

    for (int row = 0; row < NUM_ROWS; row++) begin
      send_frame(row);
      check_frame(row);
    end
    drive_blank(V_GAP, 1'b0); // close the last frame

    $display("errors: %0d mismatch, %0d unexpected write, %0d missing write, %0d other",
             mismatch_count, unexpected_count, missing_count, other_count);
    if (mismatch_count + unexpected_count + missing_count + other_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
source/camera_pkg.sv
source/frame_buffer_pkg.sv
source/camera_input_sync.sv
source/pixel_reconstruct.sv
source/frame_writer.sv
source/camera_capture.sv
bench/camera_capture_props.sv
bench/tb_camera_capture.sv

// ==== run.sh ====
#!/bin/sh
# builds the camera capture testbench with Verilator and runs it
# a run passes only when its output carries the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_camera_capture \
  -Mdir obj_dir \
  -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# assertion errors are reported and the run goes on to its summary
sim_output=$(./obj_dir/Vtb_camera_capture +verilator+error+limit+1000)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_output" | grep -qF '** PASS **'; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1
